//--- hdl/fractal_defines.svh
`ifndef FRACTAL_DEFINES_SVH
`define FRACTAL_DEFINES_SVH

// fixed point format, 10 integer and 10 fraction bits
`define FX_WIDTH 20
`define FX_FRAC 10

// iteration counter width, limits max_iter to 255
`define ITER_WIDTH 8

// pixel column and row index width
`define COORD_WIDTH 8

// |z|^2 threshold, 4.0 scaled by 2^FX_FRAC
`define ESCAPE_LIMIT 4096

`endif

//--- hdl/fractal_pkg.sv
`include "fractal_defines.svh"

package fractal_pkg;

	// signed fixed point number
	typedef logic signed [`FX_WIDTH-1:0] fx_t;

	typedef struct packed {
		fx_t re;
		fx_t im;
	} complex_t;

	// origin is the c of pixel 0,0; width and height are counts minus one
	typedef struct packed {
		complex_t origin;
		fx_t step;
		logic [`COORD_WIDTH-1:0] width;
		logic [`COORD_WIDTH-1:0] height;
	} region_t;

	// state carried around the scheduler and calculator loop
	typedef struct packed {
		complex_t z;
		complex_t c;
		logic [`ITER_WIDTH-1:0] iter;
	} iter_state_t;

	typedef struct packed {
		logic [`COORD_WIDTH-1:0] x;
		logic [`COORD_WIDTH-1:0] y;
		logic [`ITER_WIDTH-1:0] count;
	} pixel_result_t;

endpackage

//--- hdl/pixel_calculator.sv
`include "fractal_defines.svh"

module pixel_calculator (
	input logic tb_clk,
	input logic rst_n,
	input logic step_en,
	input fractal_pkg::iter_state_t state_in,
	output fractal_pkg::iter_state_t state_out,
	output logic escaped,
	output logic out_valid
);

	// products are kept at double width before scaling
	localparam int WIDE = 2 * `FX_WIDTH;

	// escape threshold at the width of the magnitude sum
	localparam logic signed [WIDE-1:0] ESCAPE_WIDE = WIDE'(`ESCAPE_LIMIT);

	// local signed copies of the incoming state
	fractal_pkg::fx_t z_re;
	fractal_pkg::fx_t z_im;
	fractal_pkg::fx_t c_re;
	fractal_pkg::fx_t c_im;

	// raw full width products
	logic signed [WIDE-1:0] re_sq_full;
	logic signed [WIDE-1:0] im_sq_full;
	logic signed [WIDE-1:0] cross_full;

	// products rescaled to the fixed point grid
	logic signed [WIDE-1:0] re_sq;
	logic signed [WIDE-1:0] im_sq;
	logic signed [WIDE-1:0] cross_x2;

	logic signed [WIDE-1:0] mag;
	logic signed [WIDE-1:0] next_re_wide;
	logic signed [WIDE-1:0] next_im_wide;
	logic escape_now;

	fractal_pkg::iter_state_t next_state;

	assign z_re = state_in.z.re;
	assign z_im = state_in.z.im;
	assign c_re = state_in.c.re;
	assign c_im = state_in.c.im;

	// three multipliers, all signed at full width
	assign re_sq_full = z_re * z_re;
	assign im_sq_full = z_im * z_im;
	assign cross_full = z_re * z_im;

	// arithmetic shift, rounds toward minus infinity
	assign re_sq = re_sq_full >>> `FX_FRAC;
	assign im_sq = im_sq_full >>> `FX_FRAC;
	// the factor 2 folds into a shift one bit shorter
	assign cross_x2 = cross_full >>> (`FX_FRAC - 1);

	// squared magnitude of the current z
	assign mag = re_sq + im_sq;
	assign escape_now = mag > ESCAPE_WIDE;

	// z^2 + c, sign extension of c comes from the signed context
	assign next_re_wide = re_sq - im_sq + c_re;
	assign next_im_wide = cross_x2 + c_im;

	always_comb
	begin
		// escaped point holds z and iter as they are
		next_state = state_in;
		if (!escape_now)
		begin
			// result wraps to the number width
			next_state.z.re = next_re_wide[`FX_WIDTH-1:0];
			next_state.z.im = next_im_wide[`FX_WIDTH-1:0];
			next_state.iter = state_in.iter + 1'b1;
		end
	end

	// strobe and escape flag
	always_ff @(posedge tb_clk)
	begin
		if (!rst_n)
		begin
			out_valid <= 1'b0;
			escaped <= 1'b0;
		end
		else
		begin
			out_valid <= step_en;
			if (step_en)
			begin
				escaped <= escape_now;
			end
		end
	end

	// state register, loaded once per step
	always_ff @(posedge tb_clk)
	begin
		if (step_en)
		begin
			state_out <= next_state;
		end
	end

endmodule

//--- hdl/plane_mapper.sv
`include "fractal_defines.svh"

module plane_mapper (
	input logic tb_clk,
	input logic rst_n,
	input logic frame_load,
	input logic advance,
	input fractal_pkg::region_t region,
	output logic [`COORD_WIDTH-1:0] x,
	output logic [`COORD_WIDTH-1:0] y,
	output fractal_pkg::complex_t c,
	output logic last
);

	// region copy for the running frame
	fractal_pkg::region_t region_q;

	logic row_end;

	assign row_end = (x == region_q.width);
	// final pixel of the raster
	assign last = row_end && (y == region_q.height);

	// grid counters and bounds
	always_ff @(posedge tb_clk)
	begin
		if (!rst_n)
		begin
			region_q <= '0;
			x <= '0;
			y <= '0;
		end
		else if (frame_load)
		begin
			region_q <= region;
			x <= '0;
			y <= '0;
		end
		else if (advance)
		begin
			if (row_end)
			begin
				x <= '0;
				y <= y + 1'b1;
			end
			else
			begin
				x <= x + 1'b1;
			end
		end
	end

	// running c, additions only
	always_ff @(posedge tb_clk)
	begin
		if (frame_load)
		begin
			c <= region.origin;
		end
		else if (advance)
		begin
			if (row_end)
			begin
				// back to left edge, one row down
				c.re <= region_q.origin.re;
				c.im <= c.im + region_q.step;
			end
			else
			begin
				c.re <= c.re + region_q.step;
			end
		end
	end

endmodule

//--- hdl/pixel_scheduler.sv
`include "fractal_defines.svh"

module pixel_scheduler (
	input logic tb_clk,
	input logic rst_n,
	input logic start,
	input logic [`ITER_WIDTH-1:0] max_iter,
	input fractal_pkg::complex_t map_c,
	input logic [`COORD_WIDTH-1:0] map_x,
	input logic [`COORD_WIDTH-1:0] map_y,
	input logic map_last,
	output logic frame_load,
	output logic advance,
	output logic step_en,
	output fractal_pkg::iter_state_t state_in,
	input fractal_pkg::iter_state_t state_out,
	input logic escaped,
	input logic out_valid,
	output logic busy,
	output logic pixel_valid,
	output logic frame_done,
	output fractal_pkg::pixel_result_t pixel
);

	typedef enum logic [1:0] {
		st_idle,
		st_load,
		st_iterate,
		st_finish
	} sched_state_t;

	sched_state_t state_q;
	sched_state_t state_d;

	logic hit_limit;
	logic pixel_done;
	logic [`ITER_WIDTH-1:0] count;

	// limit reached on the returned state
	assign hit_limit = state_out.iter >= max_iter;
	assign pixel_done = out_valid && (escaped || hit_limit);
	// a non-escaping point reports the limit itself
	// keeps max_iter 0 from reporting 1
	assign count = escaped ? state_out.iter : max_iter;

	// frame in progress whenever the FSM is away from idle
	assign busy = (state_q != st_idle);

	always_comb
	begin
		frame_load = 1'b0;
		advance = 1'b0;
		step_en = 1'b0;
		// default path recirculates the returned state
		state_in = state_out;
		state_d = state_q;
		case (state_q)
			st_idle:
			begin
				// start only seen here, ignored while busy
				if (start)
				begin
					frame_load = 1'b1;
					state_d = st_load;
				end
			end
			st_load:
			begin
				// seed z = 0, iter = 0, c from the mapper
				step_en = 1'b1;
				state_in.z = '0;
				state_in.c = map_c;
				state_in.iter = '0;
				state_d = st_iterate;
			end
			st_iterate:
			begin
				if (pixel_done)
				begin
					state_d = st_finish;
				end
				else if (out_valid)
				begin
					step_en = 1'b1;
				end
			end
			st_finish:
			begin
				if (map_last)
				begin
					state_d = st_idle;
				end
				else
				begin
					// mapper moves on, new c ready in load
					advance = 1'b1;
					state_d = st_load;
				end
			end
			default:
			begin
				state_d = st_idle;
			end
		endcase
	end

	always_ff @(posedge tb_clk)
	begin
		if (!rst_n)
		begin
			state_q <= st_idle;
			pixel_valid <= 1'b0;
			frame_done <= 1'b0;
		end
		else
		begin
			state_q <= state_d;
			// strobe lands in the finish cycle
			pixel_valid <= (state_q == st_iterate) && pixel_done;
			// one cycle after the last pixel strobe
			frame_done <= (state_q == st_finish) && map_last;
		end
	end

	// result capture, mapper still on this pixel
	always_ff @(posedge tb_clk)
	begin
		if ((state_q == st_iterate) && pixel_done)
		begin
			pixel.x <= map_x;
			pixel.y <= map_y;
			pixel.count <= count;
		end
	end

endmodule

//--- hdl/mandelbrot_engine.sv
`include "fractal_defines.svh"

module mandelbrot_engine (
	input logic tb_clk,
	input logic rst_n,
	input logic start,
	input fractal_pkg::region_t region,
	input logic [`ITER_WIDTH-1:0] max_iter,
	output logic busy,
	output logic pixel_valid,
	output logic frame_done,
	output fractal_pkg::pixel_result_t pixel
);

	// mapper to scheduler
	fractal_pkg::complex_t map_c;
	logic [`COORD_WIDTH-1:0] map_x;
	logic [`COORD_WIDTH-1:0] map_y;
	logic map_last;
	logic frame_load;
	logic advance;

	// scheduler to calculator loop
	logic step_en;
	fractal_pkg::iter_state_t state_in;
	fractal_pkg::iter_state_t state_out;
	logic escaped;
	logic out_valid;

	plane_mapper plane_mapper_i (
		.tb_clk(tb_clk),
		.rst_n(rst_n),
		.frame_load(frame_load),
		.advance(advance),
		.region(region),
		.x(map_x),
		.y(map_y),
		.c(map_c),
		.last(map_last)
	);

	pixel_scheduler pixel_scheduler_i (
		.tb_clk(tb_clk),
		.rst_n(rst_n),
		.start(start),
		.max_iter(max_iter),
		.map_c(map_c),
		.map_x(map_x),
		.map_y(map_y),
		.map_last(map_last),
		.frame_load(frame_load),
		.advance(advance),
		.step_en(step_en),
		.state_in(state_in),
		.state_out(state_out),
		.escaped(escaped),
		.out_valid(out_valid),
		.busy(busy),
		.pixel_valid(pixel_valid),
		.frame_done(frame_done),
		.pixel(pixel)
	);

	pixel_calculator pixel_calculator_i (
		.tb_clk(tb_clk),
		.rst_n(rst_n),
		.step_en(step_en),
		.state_in(state_in),
		.state_out(state_out),
		.escaped(escaped),
		.out_valid(out_valid)
	);

endmodule

//--- tb/mandelbrot_engine_props.sv
`include "fractal_defines.svh"

module mandelbrot_engine_props (
	input logic tb_clk,
	input logic rst_n,
	input logic [`ITER_WIDTH-1:0] max_iter,
	input logic step_en,
	input logic busy,
	input logic pixel_valid,
	input logic frame_done,
	input fractal_pkg::pixel_result_t pixel
);

	// results only inside a frame
	valid_in_frame: assert property (@(posedge tb_clk) disable iff (!rst_n)
		pixel_valid |-> busy)
		else $error("pixel_valid while busy is low");

	// single cycle end of frame pulse
	done_one_cycle: assert property (@(posedge tb_clk) disable iff (!rst_n)
		frame_done |=> !frame_done)
		else $error("frame_done wider than one cycle");

	// count bounded by the runtime limit
	count_in_range: assert property (@(posedge tb_clk) disable iff (!rst_n)
		pixel_valid |-> (pixel.count <= max_iter))
		else $error("pixel.count above max_iter");

	// result cycle never overlaps a calculator step
	no_step_on_result: assert property (@(posedge tb_clk) disable iff (!rst_n)
		!(step_en && pixel_valid))
		else $error("step_en and pixel_valid high together");

endmodule

// checker on the scheduler ports inside the engine
bind pixel_scheduler mandelbrot_engine_props mandelbrot_engine_props_i (
	.tb_clk(tb_clk),
	.rst_n(rst_n),
	.max_iter(max_iter),
	.step_en(step_en),
	.busy(busy),
	.pixel_valid(pixel_valid),
	.frame_done(frame_done),
	.pixel(pixel)
);

//--- tb/mandelbrot_engine_tb.sv
`include "fractal_defines.svh"

module mandelbrot_engine_tb;

	// frame table capacity
	localparam int MAX_FRAMES = 8;
	// inputs change this long after the rising edge
	localparam int DRIVE_DLY = 2;
	// reset, idle and gaps between frames
	localparam int MARGIN = 100;

	logic tb_clk;
	logic rst_n;
	logic start;
	fractal_pkg::region_t region;
	logic [`ITER_WIDTH-1:0] max_iter;
	logic busy;
	logic pixel_valid;
	logic frame_done;
	fractal_pkg::pixel_result_t pixel;

	// per frame values from the data file
	int nframes;
	int f_ore [MAX_FRAMES];
	int f_oim [MAX_FRAMES];
	int f_step [MAX_FRAMES];
	int f_w [MAX_FRAMES];
	int f_h [MAX_FRAMES];
	int f_max [MAX_FRAMES];
	int f_base [MAX_FRAMES];
	// expected counts of all frames in raster order
	logic [`ITER_WIDTH-1:0] exp_counts [$];

	// scoreboard state
	int errors;
	int pixels_checked;
	int frame_pulses;
	int cur_frame;
	int count_base;
	int frame_pixels;
	int pix_seen;
	logic [`COORD_WIDTH-1:0] exp_x;
	logic [`COORD_WIDTH-1:0] exp_y;
	logic started;
	logic frame_end_seen;

	// watchdog
	int cycle_count;
	int cycle_limit;
	logic limit_ready;

	mandelbrot_engine mandelbrot_engine_i (
		.tb_clk(tb_clk),
		.rst_n(rst_n),
		.start(start),
		.region(region),
		.max_iter(max_iter),
		.busy(busy),
		.pixel_valid(pixel_valid),
		.frame_done(frame_done),
		.pixel(pixel)
	);

	initial
	begin
		tb_clk = 1'b0;
	end

	// period 20
	always #10 tb_clk = ~tb_clk;

	always @(posedge tb_clk)
	begin
		cycle_count <= cycle_count + 1;
	end

	task automatic log_error(input string msg);
		errors = errors + 1;
		$display("%s", msg);
	endtask

	// two header lines then six values and the expected counts per frame
	task automatic load_frame_table();
		int fd;
		int rc;
		int ore;
		int oim;
		int stp;
		int w;
		int h;
		int mi;
		int v;
		int k;
		string line;
		logic more;
		nframes = 0;
		fd = $fopen("tb/frame_input.txt", "r");
		if (fd == 0)
		begin
			log_error("could not open tb/frame_input.txt");
		end
		else
		begin
			rc = $fgets(line, fd);
			rc = $fgets(line, fd);
			more = 1'b1;
			while (more && nframes < MAX_FRAMES)
			begin
				rc = $fscanf(fd, "%d %d %d %d %d %d", ore, oim, stp, w, h, mi);
				if (rc != 6)
				begin
					more = 1'b0;
				end
				else
				begin
					f_ore[nframes] = ore;
					f_oim[nframes] = oim;
					f_step[nframes] = stp;
					f_w[nframes] = w;
					f_h[nframes] = h;
					f_max[nframes] = mi;
					f_base[nframes] = exp_counts.size();
					for (k = 0; k < (w + 1) * (h + 1); k++)
					begin
						rc = $fscanf(fd, "%d", v);
						if (rc != 1)
						begin
							log_error($sformatf("data file ends inside frame %0d", nframes));
						end
						exp_counts.push_back(`ITER_WIDTH'(v));
					end
					nframes = nframes + 1;
				end
			end
			$fclose(fd);
			if (nframes == 0)
			begin
				log_error("no frames found in tb/frame_input.txt");
			end
		end
	endtask

	// worst case per pixel is max_iter + 3 cycles
	function automatic int cycle_budget();
		int sum;
		int k;
		sum = 0;
		for (k = 0; k < nframes; k++)
		begin
			sum = sum + (f_w[k] + 1) * (f_h[k] + 1) * (f_max[k] + 3);
		end
		return sum;
	endfunction

	task automatic render_frame(input int fi);
		@(posedge tb_clk);
		#DRIVE_DLY;
		region.origin.re = fractal_pkg::fx_t'(f_ore[fi]);
		region.origin.im = fractal_pkg::fx_t'(f_oim[fi]);
		region.step = fractal_pkg::fx_t'(f_step[fi]);
		region.width = `COORD_WIDTH'(f_w[fi]);
		region.height = `COORD_WIDTH'(f_h[fi]);
		max_iter = `ITER_WIDTH'(f_max[fi]);
		cur_frame = fi;
		count_base = f_base[fi];
		frame_pixels = (f_w[fi] + 1) * (f_h[fi] + 1);
		pix_seen = 0;
		exp_x = '0;
		exp_y = '0;
		frame_end_seen = 1'b0;
		started = 1'b1;
		start = 1'b1;
		@(posedge tb_clk);
		#DRIVE_DLY;
		start = 1'b0;
		if (fi == 0)
		begin
			// second start after two pixels must not restart the raster
			while (pix_seen < 2 && !frame_end_seen)
			begin
				@(posedge tb_clk);
			end
			#DRIVE_DLY;
			assert (busy)
			else
				log_error("busy low while the first frame is still rendering");
			start = 1'b1;
			@(posedge tb_clk);
			#DRIVE_DLY;
			start = 1'b0;
		end
		while (!frame_end_seen)
		begin
			@(posedge tb_clk);
		end
		repeat (3) @(posedge tb_clk);
	endtask

	task automatic score_pixel();
		logic [`ITER_WIDTH-1:0] want;
		if (pix_seen >= frame_pixels)
		begin
			log_error($sformatf("pixel_valid beyond the %0d pixels of frame %0d",
				frame_pixels, cur_frame));
		end
		else
		begin
			want = exp_counts[count_base + pix_seen];
			assert (pixel.x == exp_x)
			else
				log_error($sformatf("mismatch pixel.x: got %h, expected %h", pixel.x, exp_x));
			assert (pixel.y == exp_y)
			else
				log_error($sformatf("mismatch pixel.y: got %h, expected %h", pixel.y, exp_y));
			assert (pixel.count == want)
			else
				log_error($sformatf("mismatch pixel.count: got %h, expected %h at x %h y %h",
					pixel.count, want, exp_x, exp_y));
			assert (pixel.count <= max_iter)
			else
				log_error($sformatf("mismatch pixel.count: got %h, above max_iter %h",
					pixel.count, max_iter));
			pixels_checked = pixels_checked + 1;
			pix_seen = pix_seen + 1;
			// raster walk with columns first
			if (exp_x == region.width)
			begin
				exp_x = '0;
				exp_y = exp_y + `COORD_WIDTH'(1);
			end
			else
			begin
				exp_x = exp_x + `COORD_WIDTH'(1);
			end
		end
	endtask

	task automatic close_frame();
		frame_pulses = frame_pulses + 1;
		assert (!frame_end_seen)
		else
			log_error($sformatf("second frame_done in frame %0d", cur_frame));
		assert (pix_seen == frame_pixels)
		else
			log_error($sformatf("frame_done after %0d of %0d pixels in frame %0d",
				pix_seen, frame_pixels, cur_frame));
		assert (!busy)
		else
			log_error($sformatf("busy still high at frame_done in frame %0d", cur_frame));
		frame_end_seen = 1'b1;
	endtask

	// monitor samples on the falling edge where outputs are settled
	always @(negedge tb_clk)
	begin
		if (rst_n && !started)
		begin
			assert (!busy && !pixel_valid && !frame_done)
			else
				log_error("engine active before any start");
		end
		if (rst_n && started && pixel_valid)
		begin
			score_pixel();
		end
		if (rst_n && started && frame_done)
		begin
			close_frame();
		end
	end

	initial
	begin
		wait (limit_ready);
		while (cycle_count < cycle_limit)
		begin
			@(posedge tb_clk);
		end
		$display("timeout: frame %0d not finished after %0d cycles", cur_frame, cycle_count);
		$display("test failed");
		$finish;
	end

	initial
	begin
		int fi;
		rst_n = 1'b0;
		start = 1'b0;
		region = '0;
		max_iter = '0;
		errors = 0;
		pixels_checked = 0;
		frame_pulses = 0;
		cur_frame = 0;
		count_base = 0;
		frame_pixels = 0;
		pix_seen = 0;
		exp_x = '0;
		exp_y = '0;
		started = 1'b0;
		frame_end_seen = 1'b0;
		cycle_count = 0;
		cycle_limit = 0;
		limit_ready = 1'b0;
		load_frame_table();
		cycle_limit = cycle_budget() + MARGIN;
		limit_ready = 1'b1;
		repeat (3) @(posedge tb_clk);
		#DRIVE_DLY;
		rst_n = 1'b1;
		// quiet window before the first frame
		repeat (5) @(posedge tb_clk);
		for (fi = 0; fi < nframes; fi++)
		begin
			render_frame(fi);
		end
		assert (frame_pulses == nframes)
		else
			log_error($sformatf("%0d frame_done pulses for %0d frames", frame_pulses, nframes));
		$display("frames %0d, pixels checked %0d, frame_done pulses %0d, errors %0d",
			nframes, pixels_checked, frame_pulses, errors);
		if (errors == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

endmodule

//--- tb/frame_input.txt
# frame line: origin_re origin_im step width height max_iter (fixed point, 1.0 = 1024, width and height are counts minus one)
# then height+1 rows of width+1 expected iteration counts in raster order
-512 -256 256 3 2 10
10 10 10 10
10 10 10 10
10 10 10 10

2560 512 256 2 1 10
1 1 1
1 1 1

-2048 -2048 2048 1 1 1
1 1
1 1

0 0 256 4 1 12
12 12 5 3 3
12 12 5 3 2

//--- verilog.f
+incdir+hdl
hdl/fractal_pkg.sv
hdl/pixel_calculator.sv
hdl/plane_mapper.sv
hdl/pixel_scheduler.sv
hdl/mandelbrot_engine.sv
tb/mandelbrot_engine_props.sv
tb/mandelbrot_engine_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build with Verilator, run, then look for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal -f verilog.f \
	--top-module mandelbrot_engine_tb -o sim_tb > build.log 2>&1 &&
	./obj_dir/sim_tb > sim.log 2>&1
grep -qx "test passed" sim.log && echo "simulation PASS" ||
	{ echo "simulation FAIL, see build.log and sim.log"; exit 1; }
